// ==== hw/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and instruction width
`define RV_XLEN 32

// architectural register file
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

// first fetch address and pc step
`define RV_RESET_PC 32'h0000_0000
`define RV_INSTR_BYTES 32'd4

// shift amount taken from the low bits of operand b
`define RV_SHAMT_W 5

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_defs.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

	// major opcodes handled by decode
	typedef enum logic [6:0] {
		OP_REG   = 7'b0110011,
		OP_IMM   = 7'b0010011,
		OP_LUI   = 7'b0110111,
		OP_AUIPC = 7'b0010111
	} opcode_e;

	// operations performed in execute
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_LUI,
		ALU_AUIPC,
		// unsupported encodings land here and write nothing
		ALU_NONE
	} alu_op_e;

endpackage

// ==== hw/rv_issue_if.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

// decoded instruction from decode to execute
interface rv_issue_if;

	logic valid;
	rv_pkg::alu_op_e alu_op;
	logic use_imm;
	rv_pkg::reg_addr_t rs1;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::reg_addr_t rd;
	rv_pkg::word_t imm;
	rv_pkg::word_t pc;

	modport decode (
		output valid, alu_op, use_imm,
		output rs1, rs2, rd,
		output imm, pc
	);

	modport execute (
		input valid, alu_op, use_imm,
		input rs1, rs2, rd,
		input imm, pc
	);

endinterface

// ==== hw/rv_fetch.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_fetch (
	input logic clk,
	input logic reset,
	output rv_pkg::word_t o_pc_addr,
	output logic o_pc_rd,
	output logic o_fetch_valid,
	output rv_pkg::word_t o_fetch_pc
);

	rv_pkg::word_t pc;
	logic pc_rd;

	// strobe rises one cycle after reset, then stays high
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RV_RESET_PC;
			pc_rd <= 1'b0;
		end else begin
			pc_rd <= 1'b1;
			if (pc_rd) begin
				pc <= pc + `RV_INSTR_BYTES;
			end
		end
	end

	// memory answers one cycle later, so tag the word with its pc
	always_ff @(posedge clk) begin
		if (reset) begin
			o_fetch_valid <= 1'b0;
		end else begin
			o_fetch_valid <= pc_rd;
		end
	end

	always_ff @(posedge clk) begin
		o_fetch_pc <= pc;
	end

	assign o_pc_addr = pc;
	assign o_pc_rd = pc_rd;

	a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
		o_pc_rd |-> (o_pc_addr[1:0] == 2'b00));

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_decode (
	input logic clk,
	input logic reset,
	input rv_pkg::word_t i_instr,
	input logic i_fetch_valid,
	input rv_pkg::word_t i_fetch_pc,
	rv_issue_if.decode issue
);

	rv_pkg::opcode_e opcode;
	rv_pkg::reg_addr_t rs1;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::reg_addr_t rd;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm;
	rv_pkg::alu_op_e alu_op;
	logic use_imm;

	// instruction fields
	assign opcode = rv_pkg::opcode_e'(i_instr[6:0]);
	assign rd = i_instr[11:7];
	assign funct3 = i_instr[14:12];
	assign rs1 = i_instr[19:15];
	assign rs2 = i_instr[24:20];
	assign funct7 = i_instr[31:25];

	assign imm_i = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
	assign imm_u = {i_instr[31:12], 12'b0};

	// opcode, funct3 and funct7 folded into one alu op
	always_comb begin
		alu_op = rv_pkg::ALU_NONE;
		use_imm = 1'b0;
		imm = imm_i;
		case (opcode)
			rv_pkg::OP_REG: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'd0: alu_op = rv_pkg::ALU_ADD;
						3'd1: alu_op = rv_pkg::ALU_SLL;
						3'd2: alu_op = rv_pkg::ALU_SLT;
						3'd3: alu_op = rv_pkg::ALU_SLTU;
						3'd4: alu_op = rv_pkg::ALU_XOR;
						3'd5: alu_op = rv_pkg::ALU_SRL;
						3'd6: alu_op = rv_pkg::ALU_OR;
						default: alu_op = rv_pkg::ALU_AND;
					endcase
				end else if (funct7 == 7'b0100000) begin
					if (funct3 == 3'd0) begin
						alu_op = rv_pkg::ALU_SUB;
					end else if (funct3 == 3'd5) begin
						alu_op = rv_pkg::ALU_SRA;
					end
				end
			end
			rv_pkg::OP_IMM: begin
				use_imm = 1'b1;
				case (funct3)
					3'd0: alu_op = rv_pkg::ALU_ADD;
					3'd2: alu_op = rv_pkg::ALU_SLT;
					3'd3: alu_op = rv_pkg::ALU_SLTU;
					3'd4: alu_op = rv_pkg::ALU_XOR;
					3'd6: alu_op = rv_pkg::ALU_OR;
					3'd7: alu_op = rv_pkg::ALU_AND;
					3'd1: begin
						if (funct7 == 7'b0000000) begin
							alu_op = rv_pkg::ALU_SLL;
						end
					end
					default: begin
						// funct3 5 picks srli or srai by imm[30]
						if (funct7 == 7'b0000000) begin
							alu_op = rv_pkg::ALU_SRL;
						end else if (funct7 == 7'b0100000) begin
							alu_op = rv_pkg::ALU_SRA;
						end
					end
				endcase
			end
			rv_pkg::OP_LUI: begin
				alu_op = rv_pkg::ALU_LUI;
				use_imm = 1'b1;
				imm = imm_u;
			end
			rv_pkg::OP_AUIPC: begin
				alu_op = rv_pkg::ALU_AUIPC;
				use_imm = 1'b1;
				imm = imm_u;
			end
			default: alu_op = rv_pkg::ALU_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= i_fetch_valid;
		end
	end

	// payload only loads with a returning word
	always_ff @(posedge clk) begin
		if (i_fetch_valid) begin
			issue.alu_op <= alu_op;
			issue.use_imm <= use_imm;
			issue.rs1 <= rs1;
			issue.rs2 <= rs2;
			issue.rd <= rd;
			issue.imm <= imm;
			issue.pc <= i_fetch_pc;
		end
	end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_execute (
	input logic clk,
	input logic reset,
	rv_issue_if.execute issue,
	input rv_pkg::word_t i_rs1_data,
	input rv_pkg::word_t i_rs2_data,
	output rv_pkg::reg_addr_t o_rs1_addr,
	output rv_pkg::reg_addr_t o_rs2_addr,
	output logic o_wb_valid,
	output rv_pkg::reg_addr_t o_wb_rd,
	output rv_pkg::word_t o_wb_data
);

	logic fwd_rs1;
	logic fwd_rs2;
	rv_pkg::word_t op_a;
	rv_pkg::word_t rs2_val;
	rv_pkg::word_t op_b;
	logic [`RV_SHAMT_W-1:0] shamt;
	rv_pkg::word_t alu_out;
	logic writes;

	// register file reads at the issued indices
	assign o_rs1_addr = issue.rs1;
	assign o_rs2_addr = issue.rs2;

	// previous instruction is still in the result register, not yet written back.
	// o_wb_valid is already low for x0 and for no-op
	assign fwd_rs1 = o_wb_valid && (o_wb_rd == issue.rs1);
	assign fwd_rs2 = o_wb_valid && (o_wb_rd == issue.rs2);

	assign op_a = fwd_rs1 ? o_wb_data : i_rs1_data;
	assign rs2_val = fwd_rs2 ? o_wb_data : i_rs2_data;
	assign op_b = issue.use_imm ? issue.imm : rs2_val;

	// only the low bits count as shift amount
	assign shamt = op_b[`RV_SHAMT_W-1:0];

	always_comb begin
		case (issue.alu_op)
			rv_pkg::ALU_ADD: alu_out = op_a + op_b;
			rv_pkg::ALU_SUB: alu_out = op_a - op_b;
			rv_pkg::ALU_XOR: alu_out = op_a ^ op_b;
			rv_pkg::ALU_OR: alu_out = op_a | op_b;
			rv_pkg::ALU_AND: alu_out = op_a & op_b;
			rv_pkg::ALU_SLL: alu_out = op_a << shamt;
			rv_pkg::ALU_SRL: alu_out = op_a >> shamt;
			rv_pkg::ALU_SRA: alu_out = rv_pkg::word_t'($signed(op_a) >>> shamt);
			rv_pkg::ALU_SLT: begin
				alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			rv_pkg::ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			rv_pkg::ALU_LUI: alu_out = issue.imm;
			rv_pkg::ALU_AUIPC: alu_out = issue.pc + issue.imm;
			default: alu_out = '0;
		endcase
	end

	// x0 targets and no-ops never reach write-back
	assign writes = issue.valid && (issue.rd != '0) && (issue.alu_op != rv_pkg::ALU_NONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= writes;
		end
	end

	always_ff @(posedge clk) begin
		if (issue.valid) begin
			o_wb_rd <= issue.rd;
			o_wb_data <= alu_out;
		end
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
		o_wb_valid |-> (o_wb_rd != '0));

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_regfile (
	input logic clk,
	input logic reset,
	input logic i_wb_valid,
	input rv_pkg::reg_addr_t i_wb_rd,
	input rv_pkg::word_t i_wb_data,
	input rv_pkg::reg_addr_t i_rs1_addr,
	input rv_pkg::reg_addr_t i_rs2_addr,
	output rv_pkg::word_t o_rs1_data,
	output rv_pkg::word_t o_rs2_data
);

	rv_pkg::word_t regs [`RV_REG_COUNT];

	// x0 is never written and keeps its reset zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_valid && (i_wb_rd != '0)) begin
			regs[i_wb_rd] <= i_wb_data;
		end
	end

	// combinational read ports
	assign o_rs1_data = regs[i_rs1_addr];
	assign o_rs2_data = regs[i_rs2_addr];

	a_x0_rs1_zero: assert property (@(posedge clk) disable iff (reset)
		(i_rs1_addr == '0) |-> (o_rs1_data == '0));

	a_x0_rs2_zero: assert property (@(posedge clk) disable iff (reset)
		(i_rs2_addr == '0) |-> (o_rs2_data == '0));

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core (
	input logic clk,
	input logic reset,
	input rv_pkg::word_t i_pc_rddata,
	output rv_pkg::word_t o_pc_addr,
	output logic o_pc_rd,
	output logic o_rf_wr_en,
	output rv_pkg::reg_addr_t o_rf_wr_addr,
	output rv_pkg::word_t o_rf_wr_data
);

	logic fetch_valid;
	rv_pkg::word_t fetch_pc;
	logic wb_valid;
	rv_pkg::reg_addr_t wb_rd;
	rv_pkg::word_t wb_data;
	rv_pkg::reg_addr_t rs1_addr;
	rv_pkg::reg_addr_t rs2_addr;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;

	rv_issue_if issue ();

	rv_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.o_pc_addr(o_pc_addr),
		.o_pc_rd(o_pc_rd),
		.o_fetch_valid(fetch_valid),
		.o_fetch_pc(fetch_pc)
	);

	rv_decode u_decode (
		.clk(clk),
		.reset(reset),
		.i_instr(i_pc_rddata),
		.i_fetch_valid(fetch_valid),
		.i_fetch_pc(fetch_pc),
		.issue(issue.decode)
	);

	rv_execute u_execute (
		.clk(clk),
		.reset(reset),
		.issue(issue.execute),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_rs1_addr(rs1_addr),
		.o_rs2_addr(rs2_addr),
		.o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd),
		.o_wb_data(wb_data)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.i_wb_valid(wb_valid),
		.i_wb_rd(wb_rd),
		.i_wb_data(wb_data),
		.i_rs1_addr(rs1_addr),
		.i_rs2_addr(rs2_addr),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	// write port seen from outside
	assign o_rf_wr_en = wb_valid;
	assign o_rf_wr_addr = wb_rd;
	assign o_rf_wr_data = wb_data;

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int RESET_CYCLES = 8;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// released on the eighth rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker (
	input logic clk,
	input logic reset,
	input logic i_pc_rd,
	input rv_pkg::word_t i_pc_addr,
	input logic i_wr_en,
	input rv_pkg::reg_addr_t i_wr_addr,
	input rv_pkg::word_t i_wr_data,
	output int o_errors,
	output int o_pending
);

	rv_pkg::word_t exp_pc [$];
	rv_pkg::reg_addr_t exp_rd [$];
	rv_pkg::word_t exp_data [$];
	rv_pkg::word_t next_pc = 32'h0;
	rv_pkg::word_t fetch_addr_hist [3];
	logic [2:0] fetch_rd_hist = 3'b000;
	logic fetching = 1'b0;
	int errors = 0;

	task add_expected_write(input rv_pkg::word_t pc, input rv_pkg::reg_addr_t rd,
			input rv_pkg::word_t data);
		exp_pc.push_back(pc);
		exp_rd.push_back(rd);
		exp_data.push_back(data);
	endtask

	task compare_word(input string name, input rv_pkg::word_t expected,
			input rv_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task check_write();
		rv_pkg::word_t pc;
		if (exp_pc.size() == 0) begin
			$display("unexpected register write to x%0d with %h", i_wr_addr, i_wr_data);
			errors++;
		end else begin
			pc = exp_pc.pop_front();
			compare_word($sformatf("write rd at pc %h", pc), 32'(exp_rd.pop_front()),
				32'(i_wr_addr));
			compare_word($sformatf("write data at pc %h", pc), exp_data.pop_front(), i_wr_data);
			// oldest history slot is the fetch of three cycles ago
			if (!fetch_rd_hist[2]) begin
				$display("write for pc %h came without a fetch three cycles earlier", pc);
				errors++;
			end else begin
				compare_word($sformatf("write latency at pc %h", pc), pc, fetch_addr_hist[2]);
			end
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (reset) begin
			if (i_pc_rd || i_wr_en) begin
				$display("fetch or write strobe high during reset at %0t", $time);
				errors++;
			end
			fetch_rd_hist = 3'b000;
		end else begin
			if (i_wr_en) begin
				check_write();
			end
			if (i_pc_rd) begin
				compare_word("fetch address", next_pc, i_pc_addr);
				next_pc = next_pc + 32'd4;
				fetching = 1'b1;
			end else if (fetching) begin
				$display("fetch strobe dropped at %0t", $time);
				errors++;
			end
			fetch_addr_hist[2] = fetch_addr_hist[1];
			fetch_addr_hist[1] = fetch_addr_hist[0];
			fetch_addr_hist[0] = i_pc_addr;
			fetch_rd_hist = {fetch_rd_hist[1:0], i_pc_rd};
		end
		o_pending = exp_pc.size();
	end

	assign o_errors = errors;

endmodule

// ==== testbench/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;

	localparam int MEM_WORDS = 64;
	localparam int RESET_CYCLES = 8;
	localparam rv_pkg::word_t NOP = 32'h0000_0013;

	logic clk;
	logic reset;
	rv_pkg::word_t pc_rddata = NOP;
	rv_pkg::word_t pc_addr;
	logic pc_rd;
	logic rf_wr_en;
	rv_pkg::reg_addr_t rf_wr_addr;
	rv_pkg::word_t rf_wr_data;
	rv_pkg::word_t imem [MEM_WORDS];
	int prog_len = 0;
	int bad_lines = 0;
	int cycles = 0;
	int cycle_limit = 0;
	logic timed_out = 1'b0;
	int errors;
	int pending;

	tb_clock clock_gen (.clk(clk), .reset(reset));

	rv_core dut (
		.clk(clk),
		.reset(reset),
		.i_pc_rddata(pc_rddata),
		.o_pc_addr(pc_addr),
		.o_pc_rd(pc_rd),
		.o_rf_wr_en(rf_wr_en),
		.o_rf_wr_addr(rf_wr_addr),
		.o_rf_wr_data(rf_wr_data)
	);

	tb_checker chk (
		.clk(clk),
		.reset(reset),
		.i_pc_rd(pc_rd),
		.i_pc_addr(pc_addr),
		.i_wr_en(rf_wr_en),
		.i_wr_addr(rf_wr_addr),
		.i_wr_data(rf_wr_data),
		.o_errors(errors),
		.o_pending(pending)
	);

	// nop past the end of the program
	function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
		if (addr[31:2] < 30'(prog_len)) begin
			return imem[addr[7:2]];
		end
		return NOP;
	endfunction

	// instruction memory with one cycle read latency
	always @(posedge clk) begin
		if (pc_rd) begin
			pc_rddata <= fetch_word(pc_addr);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			timed_out <= 1'b1;
		end
	end

	task automatic load_stimulus();
		int fd;
		int n;
		int rd;
		string line;
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		fd = $fopen("testbench/core_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/core_stim.txt");
			bad_lines++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				n = 0;
			end else if (line.getc(0) == "I" && prog_len < MEM_WORDS) begin
				n = $sscanf(line, "I %h", a);
				imem[prog_len] = a;
				prog_len++;
				bad_lines += (n == 1) ? 0 : 1;
			end else if (line.getc(0) == "W") begin
				n = $sscanf(line, "W %h %d %h", a, rd, b);
				chk.add_expected_write(a, rv_pkg::reg_addr_t'(rd), b);
				bad_lines += (n == 3) ? 0 : 1;
			end else begin
				$display("stimulus line not understood: %s", line);
				bad_lines++;
			end
		end
		$fclose(fd);
	endtask

	// checker counters change on the falling edge and are read on the rising one
	initial begin
		load_stimulus();
		cycle_limit = RESET_CYCLES + prog_len + 3 + 20;
		@(posedge clk);
		while (reset) @(posedge clk);
		while (pending != 0 && !timed_out) @(posedge clk);
		// a few more cycles to catch stray writes
		if (!timed_out) begin
			repeat (4) @(posedge clk);
		end
		if (timed_out) begin
			$display("timeout after %0d cycles, expected register writes did not all appear",
				cycles);
		end
		$display("checked: %0d mismatches, %0d missing writes, %0d bad stimulus lines",
			errors, pending, bad_lines);
		if (errors == 0 && pending == 0 && bad_lines == 0 && !timed_out) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_issue_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_core.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_core -o sim_core
./obj_dir/sim_core > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/core_stim.txt ====
# I <instruction hex> <assembly>, placed from address 0 in program order
# W <pc hex> <rd decimal> <data hex>, expected register writes in program order
I 800000b7 lui x1,0x80000
W 00000000 1 80000000
I ff900113 addi x2,x0,-7
W 00000004 2 fffffff9
I 02300193 addi x3,x0,35
W 00000008 3 00000023
I 4030d233 sra x4,x1,x3
W 0000000c 4 f0000000
I 003252b3 srl x5,x4,x3
W 00000010 5 1e000000
I 00329333 sll x6,x5,x3
W 00000014 6 f0000000
I 003123b3 slt x7,x2,x3
W 00000018 7 00000001
I 00313433 sltu x8,x2,x3
W 0000001c 8 00000000
I 402184b3 sub x9,x3,x2
W 00000020 9 0000002a
I 00948533 add x10,x9,x9
W 00000024 10 00000054
I 009545b3 xor x11,x10,x9
W 00000028 11 0000007e
I 0015e633 or x12,x11,x1
W 0000002c 12 8000007e
I 002676b3 and x13,x12,x2
W 00000030 13 80000078
I fff13713 sltiu x14,x2,-1
W 00000034 14 00000001
I 00411793 slli x15,x2,4
W 00000038 15 ffffff90
I 01f0d813 srli x16,x1,31
W 0000003c 16 00000001
I 4027d893 srai x17,x15,2
W 00000040 17 ffffffe4
I 12345917 auipc x18,0x12345
W 00000044 18 12345044
I 00510013 addi x0,x2,5
I 001069b3 or x19,x0,x1
W 0000004c 19 80000000
I 02310a33 mul x20,x2,x3
I fffa0a93 addi x21,x20,-1
W 00000054 21 ffffffff
